// ==== Makefile ====
# Verilator build and run for the scalar unit testbench

VERILATOR ?= verilator
TOP       ?= tbScalarUnit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) verif/tbModel.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/fetchUnit.sv ====
/*
 * Fetch unit: program counter, fetch register,
 * jump/branch redirect and run/halt control
 */
`timescale 1ns/1ns

module fetchUnit
	import scalarPkg::*;
#(
	parameter int ImemDepth = 64
)(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         en,
	input  logic                         stall,
	input  instrT                        fetchInstr,
	input  redirectT                     redirect,
	input  logic                         haltDone,
	output logic [$clog2(ImemDepth)-1:0] fetchAddr,
	output instrT                        instr,
	output logic                         instrValid,
	output statusT                       status
);

	localparam int AddrWidth = $clog2(ImemDepth);

	typedef enum logic [1:0] {RunIdle, RunFetch, RunWaitBranch, RunHalted} runStateT;

	runStateT             runState;
	logic [AddrWidth-1:0] pc;        // Address of the word on fetchInstr
	logic                 rdValid;   // fetchInstr holds mem[pc]
	logic                 halted;
	logic                 capture;
	logic                 isCtrl;
	logic                 isHalt;

	assign isCtrl  = (fetchInstr.opcode == OpJmp) || (fetchInstr.opcode == OpBnz);
	assign isHalt  = (fetchInstr.opcode == OpHalt);
	assign capture = (runState == RunFetch) && rdValid && !stall;

	// Read ahead only on a sequential capture, otherwise re-read pc
	assign fetchAddr = (capture && !isCtrl && !isHalt) ? pc + AddrWidth'(1) : pc;

	assign status.busy   = (runState != RunIdle);
	assign status.halted = halted;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			runState   <= RunIdle;
			pc         <= '0;
			rdValid    <= 1'b0;
			instrValid <= 1'b0;
			halted     <= 1'b0;
		end else begin
			if (capture) instrValid <= 1'b1;
			else if (!stall) instrValid <= 1'b0;   // Held word issued

			case (runState)
				RunIdle: begin
					if (en) begin
						runState <= RunFetch;
						pc       <= '0;
						rdValid  <= 1'b0;
						halted   <= 1'b0;
					end
				end
				RunFetch: begin
					if (!rdValid) begin
						rdValid <= 1'b1;
					end else if (capture) begin
						if (isCtrl) begin
							runState <= RunWaitBranch;
							rdValid  <= 1'b0;
						end else if (isHalt) begin
							runState <= RunHalted;
							rdValid  <= 1'b0;
						end else begin
							pc <= pc + AddrWidth'(1);
						end
					end
				end
				RunWaitBranch: begin
					if (redirect.valid) begin
						pc       <= redirect.taken ? redirect.target[AddrWidth-1:0]
						                           : pc + AddrWidth'(1);
						runState <= RunFetch;
					end
				end
				RunHalted: begin
					if (haltDone) begin   // HALT drained from the math unit
						runState <= RunIdle;
						halted   <= 1'b1;
					end
				end
				default: runState <= RunIdle;
			endcase
		end
	end

	// Fetch register payload
	always_ff @(posedge clock) begin
		if (capture) instr <= fetchInstr;
	end

	// Only a fetched JMP/BNZ may resolve
	assert property (@(posedge clock) disable iff (!rstN)
		redirect.valid |-> runState == RunWaitBranch);

endmodule

// ==== hdl/hazardCheck.sv ====
/*
 * Pending-write scoreboard and issue stall
 */
`timescale 1ns/1ns

module hazardCheck
	import scalarPkg::*;
(
	input  logic   clock,
	input  logic   rstN,
	input  instrT  instr,
	input  logic   instrValid,
	input  commitT wb,
	output logic   stall
);

	logic [NumRegs-1:0] pending;
	logic               useSrc1;
	logic               useSrc2;
	logic               writesDst;
	logic               issueNow;

	// Operand usage per opcode
	always_comb begin
		useSrc1   = 1'b0;
		useSrc2   = 1'b0;
		writesDst = 1'b0;
		case (instr.opcode)
			OpAdd, OpSub, OpAnd, OpOr, OpXor: begin
				useSrc1   = 1'b1;
				useSrc2   = 1'b1;
				writesDst = 1'b1;
			end
			OpAddi: begin
				useSrc1   = 1'b1;
				writesDst = 1'b1;
			end
			OpBnz:   useSrc1 = 1'b1;
			default: ;
		endcase
	end

	assign stall = instrValid && ((useSrc1 && pending[instr.src1]) ||
	                              (useSrc2 && pending[instr.src2]) ||
	                              (writesDst && pending[instr.dst]));
	assign issueNow = instrValid && !stall;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			pending <= '0;
		end else begin
			if (wb.valid) pending[wb.dst] <= 1'b0;
			if (issueNow && writesDst) pending[instr.dst] <= 1'b1;   // Never the wb reg
		end
	end

	// Every write-back matches an earlier issue
	assert property (@(posedge clock) disable iff (!rstN) wb.valid |-> pending[wb.dst]);

endmodule

// ==== hdl/instrMem.sv ====
/*
 * Instruction memory
 * Four-phase store port and registered fetch read port
 */
`timescale 1ns/1ns

module instrMem
	import scalarPkg::*;
#(
	parameter int ImemDepth = 64
)(
	input  logic                         clock,
	input  logic                         rstN,
	input  logic                         storeReq,
	input  instrT                        storeInstr,
	input  logic                         start,
	input  logic                         busy,
	input  logic [$clog2(ImemDepth)-1:0] fetchAddr,
	output logic                         storeAck,
	output instrT                        fetchInstr
);

	localparam int AddrWidth = $clog2(ImemDepth);

	typedef enum logic {StIdle, StAck} stStateT;

	stStateT              stState;
	logic [AddrWidth-1:0] wrPtr;
	instrT                mem [ImemDepth];

	assign storeAck = (stState == StAck);

	////////////////////////////////
	// Store handshake
	////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			stState <= StIdle;
			wrPtr   <= '0;
		end else begin
			case (stState)
				StIdle: begin
					if (start) begin
						wrPtr <= '0;   // New program after this run
					end else if (storeReq && !busy) begin
						wrPtr   <= wrPtr + AddrWidth'(1);
						stState <= StAck;
					end
				end
				StAck: begin
					if (!storeReq) stState <= StIdle;   // Host released req
				end
				default: stState <= StIdle;
			endcase
		end
	end

	// Word is written on the req edge seen in idle
	always_ff @(posedge clock) begin
		if (stState == StIdle && !start && storeReq && !busy) mem[wrPtr] <= storeInstr;
	end

	// Fetch port, one cycle latency
	always_ff @(posedge clock) begin
		fetchInstr <= mem[fetchAddr];
	end

	// Host must hold req until it sees ack
	assert property (@(posedge clock) disable iff (!rstN) $fell(storeReq) |-> storeAck);

endmodule

// ==== hdl/regFile.sv ====
/*
 * Register file, sixteen entries
 * Two combinational read ports, one write port
 */
`timescale 1ns/1ns

module regFile
	import scalarPkg::*;
(
	input  logic   clock,
	input  logic   rstN,
	input  regIdxT rdIdx1,
	input  regIdxT rdIdx2,
	input  commitT wb,
	output dataT   rdData1,
	output dataT   rdData2
);

	dataT regs [NumRegs];

	// Register 0 reads as zero
	assign rdData1 = (rdIdx1 == '0) ? '0 : regs[rdIdx1];
	assign rdData2 = (rdIdx2 == '0) ? '0 : regs[rdIdx2];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			regs <= '{default: '0};
		end else if (wb.valid && wb.dst != '0) begin
			regs[wb.dst] <= wb.data;   // Visible next cycle
		end
	end

endmodule

// ==== hdl/sMathUnit.sv ====
/*
 * Scalar math unit: two-stage pipeline with ALU,
 * branch resolution, commit and halt outputs
 */
`timescale 1ns/1ns

module sMathUnit
	import scalarPkg::*;
(
	input  logic     clock,
	input  logic     rstN,
	input  issueT    issue,
	output commitT   commit,
	output redirectT redirect,
	output logic     haltDone
);

	dataT     immExt;
	dataT     aluResult;
	logic     isAlu;
	commitT   s1Commit;
	redirectT s1Redirect;
	logic     s1Halt;

	assign immExt = {{(DataWidth-ImmWidth){issue.imm[ImmWidth-1]}}, issue.imm};

	////////////////////////////////
	// Stage one
	////////////////////////////////
	always_comb begin
		aluResult = '0;
		isAlu     = 1'b1;
		case (issue.opcode)
			OpAdd:   aluResult = issue.src1Data + issue.src2Data;
			OpSub:   aluResult = issue.src1Data - issue.src2Data;
			OpAnd:   aluResult = issue.src1Data & issue.src2Data;
			OpOr:    aluResult = issue.src1Data | issue.src2Data;
			OpXor:   aluResult = issue.src1Data ^ issue.src2Data;
			OpAddi:  aluResult = issue.src1Data + immExt;
			default: isAlu     = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstN) begin
			s1Commit.valid   <= 1'b0;
			s1Redirect.valid <= 1'b0;
			s1Halt           <= 1'b0;
		end else begin
			s1Commit.valid   <= issue.valid && isAlu;
			s1Redirect.valid <= issue.valid && (issue.opcode inside {OpJmp, OpBnz});
			s1Halt           <= issue.valid && (issue.opcode == OpHalt);
		end
	end

	// Payload, no reset
	always_ff @(posedge clock) begin
		s1Commit.dst      <= issue.dst;
		s1Commit.data     <= aluResult;
		s1Redirect.taken  <= (issue.opcode == OpJmp) || (issue.src1Data != '0);
		s1Redirect.target <= issue.imm;
	end

	////////////////////////////////
	// Stage two
	////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			commit.valid   <= 1'b0;
			redirect.valid <= 1'b0;
			haltDone       <= 1'b0;
		end else begin
			commit.valid   <= s1Commit.valid;
			redirect.valid <= s1Redirect.valid;
			haltDone       <= s1Halt;
		end
	end

	always_ff @(posedge clock) begin
		commit.dst      <= s1Commit.dst;
		commit.data     <= s1Commit.data;
		redirect.taken  <= s1Redirect.taken;
		redirect.target <= s1Redirect.target;
	end

	// Nothing issues behind an unresolved jump or branch
	assert property (@(posedge clock) disable iff (!rstN)
		(s1Redirect.valid || redirect.valid) |-> !issue.valid);

endmodule

// ==== hdl/scalarPkg.sv ====
/*
 * Shared scalar core definitions: widths, opcode enum,
 * instruction, issue, commit, status and redirect structs
 */
package scalarPkg;

	localparam int DataWidth   = 32;
	localparam int NumRegs     = 16;
	localparam int RegIdxWidth = 4;
	localparam int ImmWidth    = 16;

	typedef enum logic [3:0] {
		OpNop,
		OpAdd,
		OpSub,
		OpAnd,
		OpOr,
		OpXor,
		OpAddi,
		OpJmp,
		OpBnz,
		OpHalt
	} opcodeT;

	typedef logic [RegIdxWidth-1:0] regIdxT;
	typedef logic [DataWidth-1:0]   dataT;

	// Instruction word, 32 bits
	typedef struct packed {
		opcodeT               opcode;
		regIdxT               dst;
		regIdxT               src1;
		regIdxT               src2;
		logic [ImmWidth-1:0]  imm;   // Sign-extended for ADDI, target for JMP/BNZ
	} instrT;

	// Issued instruction with operand values
	typedef struct packed {
		logic                 valid;
		opcodeT               opcode;
		regIdxT               dst;
		dataT                 src1Data;
		dataT                 src2Data;
		logic [ImmWidth-1:0]  imm;
	} issueT;

	// Write-back and commit stream
	typedef struct packed {
		logic   valid;
		regIdxT dst;
		dataT   data;
	} commitT;

	typedef struct packed {
		logic busy;
		logic halted;
	} statusT;

	// Resolved jump or branch
	typedef struct packed {
		logic                 valid;
		logic                 taken;
		logic [ImmWidth-1:0]  target;
	} redirectT;

endpackage

// ==== hdl/scalarUnit.sv ====
/*
 * Scalar unit top level
 * Stage wiring and the issue register
 */
`timescale 1ns/1ns

module scalarUnit
	import scalarPkg::*;
#(
	parameter int ImemDepth = 64
)(
	input  logic   clock,
	input  logic   rstN,
	input  logic   storeReq,
	input  instrT  storeInstr,
	input  logic   en,
	output logic   storeAck,
	output commitT commit,
	output statusT status
);

	logic [$clog2(ImemDepth)-1:0] fetchAddr;
	instrT                        fetchInstr;
	instrT                        instr;
	logic                         instrValid;
	logic                         stall;
	logic                         start;
	logic                         doIssue;
	redirectT                     redirect;
	logic                         haltDone;
	dataT                         rdData1;
	dataT                         rdData2;
	issueT                        issue;

	assign start   = en && !status.busy;   // Run begins, store pointer rewinds
	assign doIssue = instrValid && !stall;

	////////////////////////////////
	// Issue register
	////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rstN) begin
			issue.valid <= 1'b0;
		end else begin
			issue.valid <= doIssue;
			if (doIssue) begin
				issue.opcode   <= instr.opcode;
				issue.dst      <= instr.dst;
				issue.src1Data <= rdData1;   // Operands read at issue
				issue.src2Data <= rdData2;
				issue.imm      <= instr.imm;
			end
		end
	end

	instrMem #(
		.ImemDepth  (ImemDepth)
	) u_instrMem (
		.clock      (clock),
		.rstN       (rstN),
		.storeReq   (storeReq),
		.storeInstr (storeInstr),
		.start      (start),
		.busy       (status.busy),
		.fetchAddr  (fetchAddr),
		.storeAck   (storeAck),
		.fetchInstr (fetchInstr)
	);

	fetchUnit #(
		.ImemDepth  (ImemDepth)
	) u_fetchUnit (
		.clock      (clock),
		.rstN       (rstN),
		.en         (en),
		.stall      (stall),
		.fetchInstr (fetchInstr),
		.redirect   (redirect),
		.haltDone   (haltDone),
		.fetchAddr  (fetchAddr),
		.instr      (instr),
		.instrValid (instrValid),
		.status     (status)
	);

	hazardCheck u_hazardCheck (
		.clock      (clock),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.wb         (commit),
		.stall      (stall)
	);

	regFile u_regFile (
		.clock      (clock),
		.rstN       (rstN),
		.rdIdx1     (instr.src1),
		.rdIdx2     (instr.src2),
		.wb         (commit),
		.rdData1    (rdData1),
		.rdData2    (rdData2)
	);

	// Commit doubles as the write-back bus
	sMathUnit u_sMathUnit (
		.clock      (clock),
		.rstN       (rstN),
		.issue      (issue),
		.commit     (commit),
		.redirect   (redirect),
		.haltDone   (haltDone)
	);

endmodule

// ==== verif/tbModel.svh ====
/*
 * Testbench reference model
 * Runs a stored program in order and queues the expected commits
 */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

task automatic modelRun(input int len);
	int    pc;
	bit    done;
	bit    writes;
	instrT w;
	dataT  a;
	dataT  b;
	dataT  res;
	pc   = 0;
	done = 1'b0;
	while (pc < len && !done) begin
		w      = prog[pc];
		a      = modelRegs[w.src1];   // r0 is kept at zero below
		b      = modelRegs[w.src2];
		res    = '0;
		writes = 1'b1;
		pc     = pc + 1;
		case (w.opcode)
			OpAdd:  res = a + b;
			OpSub:  res = a - b;
			OpAnd:  res = a & b;
			OpOr:   res = a | b;
			OpXor:  res = a ^ b;
			OpAddi: res = a + dataT'(shortint'(w.imm));
			OpJmp: begin
				writes = 1'b0;
				pc     = int'(w.imm);
				jumpCnt++;
			end
			OpBnz: begin
				writes = 1'b0;
				if (a != '0) begin
					pc = int'(w.imm);
					takenCnt++;
				end else begin
					notTakenCnt++;
				end
			end
			OpHalt: begin
				writes = 1'b0;
				done   = 1'b1;
			end
			default: writes = 1'b0;   // NOP
		endcase
		if (writes) begin
			expDst.push_back(w.dst);
			expData.push_back(res);
			if (w.dst != '0) modelRegs[w.dst] = res;
		end
	end
endtask

`endif

// ==== verif/tbScalarUnit.sv ====
/*
 * Testbench for the scalar unit
 * Random programs, store handshake driver and commit checker
 */
`timescale 1ns/1ns

module tbScalarUnit
	import scalarPkg::*;
();

	localparam int ImemDepth = 64;
	localparam int MaxProg   = 40;
	localparam int Timeout   = 2000;   // Cycles per wait

	logic   clock;
	logic   rstN;
	logic   storeReq;
	instrT  storeInstr;
	logic   en;
	logic   storeAck;
	commitT commit;
	statusT status;

	instrT  prog [MaxProg];
	dataT   modelRegs [NumRegs];   // Carries over between runs
	regIdxT expDst [$];
	dataT   expData [$];
	int     seed;
	int     errors;
	int     timeouts;
	int     commitCnt;
	int     jumpCnt;
	int     takenCnt;
	int     notTakenCnt;

	`include "tbModel.svh"

	scalarUnit #(
		.ImemDepth  (ImemDepth)
	) u_scalarUnit (
		.clock      (clock),
		.rstN       (rstN),
		.storeReq   (storeReq),
		.storeInstr (storeInstr),
		.en         (en),
		.storeAck   (storeAck),
		.commit     (commit),
		.status     (status)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	//////////////////////////////
	// Commit checker
	//////////////////////////////
	always @(negedge clock) begin
		if (rstN && commit.valid) begin
			commitCnt++;
			if (expDst.size() == 0) begin
				$display("Unexpected commit to r%0d, nothing left to retire", commit.dst);
				errors++;
			end else begin
				if (commit.dst != expDst[0]) begin
					$display("Error: commit.dst expected %h got %h", expDst[0], commit.dst);
					errors++;
				end
				if (commit.data != expData[0]) begin
					$display("Error: commit.data expected %h got %h", expData[0], commit.data);
					errors++;
				end
				expDst.delete(0);
				expData.delete(0);
			end
		end
	end

	// Four-phase store of one word
	task automatic storeWord(input instrT w);
		int n;
		@(posedge clock);
		storeReq   <= 1'b1;
		storeInstr <= w;
		n = 0;
		@(negedge clock);
		while (!storeAck && n < Timeout) begin
			@(negedge clock);
			n++;
		end
		if (!storeAck) begin
			$display("Store of a program word got no ack in time");
			timeouts++;
		end
		@(posedge clock);
		storeReq <= 1'b0;
		n = 0;
		@(negedge clock);
		while (storeAck && n < Timeout) begin
			@(negedge clock);
			n++;
		end
		if (storeAck) begin
			$display("Store ack stayed high after req was released");
			timeouts++;
		end
	endtask

	task automatic genProgram(input int mode, output int len);
		int     r;
		regIdxT prevDst;
		instrT  w;
		prevDst = '0;
		len     = (mode == 3) ? 16 : 8 + int'($unsigned($random(seed)) % 24);
		for (int i = 0; i < len - 1; i++) begin
			r      = int'($unsigned($random(seed)) % 1024);
			w.dst  = regIdxT'($random(seed));
			w.src1 = regIdxT'($random(seed));
			w.src2 = regIdxT'($random(seed));
			w.imm  = 16'($random(seed));
			w.opcode = opcodeT'(1 + r % 6);   // ALU or ADDI
			case (mode)
				1: begin   // Chain through r1..r3
					w.dst  = regIdxT'(1 + $unsigned($random(seed)) % 3);
					w.src1 = prevDst;
				end
				2: begin
					if (r % 8 < 2) begin
						w.opcode = (r % 8 == 0) ? OpJmp : OpBnz;
						w.src1   = regIdxT'($unsigned($random(seed)) % 4);
						w.imm    = 16'(i + 1 + int'($unsigned($random(seed)) % (len - 1 - i)));
					end else if (r % 8 == 2) begin
						w.opcode = OpNop;
					end
				end
				3: begin   // Read back r1..r15 through the commit stream
					w.opcode = OpAddi;
					w.dst    = regIdxT'(i + 1);
					w.src1   = regIdxT'(i + 1);
					w.imm    = '0;
				end
				default: ;
			endcase
			prevDst = w.dst;
			prog[i] = w;
		end
		w        = '0;
		w.opcode = OpHalt;
		prog[len - 1] = w;
	endtask

	// Store, predict, start and wait for HALT
	task automatic runProgram(input int len);
		int n;
		for (int i = 0; i < len; i++) storeWord(prog[i]);
		modelRun(len);
		@(posedge clock);
		en <= 1'b1;
		@(posedge clock);
		en <= 1'b0;
		n = 0;
		@(negedge clock);
		if (!status.busy) begin
			$display("Core did not go busy after the en pulse");
			errors++;
		end
		while (!(status.halted && !status.busy) && n < Timeout) begin
			@(negedge clock);
			n++;
		end
		if (!status.halted || status.busy) begin
			$display("Program did not reach HALT in time");
			timeouts++;
		end
		repeat (6) @(negedge clock);   // Anything after HALT shows up here
		if (expDst.size() != 0) begin
			$display("%0d expected commits never appeared", expDst.size());
			errors++;
			expDst.delete();
			expData.delete();
		end
	endtask

	initial begin
		int len;
		seed        = 32'h88d94fc4;
		errors      = 0;
		timeouts    = 0;
		commitCnt   = 0;
		jumpCnt     = 0;
		takenCnt    = 0;
		notTakenCnt = 0;
		rstN        = 1'b0;
		storeReq    = 1'b0;
		storeInstr  = '0;
		en          = 1'b0;
		modelRegs   = '{default: '0};
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		if (storeAck || commit.valid || status.busy || status.halted) begin
			$display("Outputs were not idle after reset");
			errors++;
		end
		// Straight-line, dependent, control flow, then register readback
		for (int k = 0; k < 3; k++) begin
			genProgram(0, len);
			runProgram(len);
		end
		for (int k = 0; k < 3; k++) begin
			genProgram(1, len);
			runProgram(len);
		end
		for (int k = 0; k < 6; k++) begin
			genProgram(2, len);
			runProgram(len);
		end
		genProgram(3, len);
		runProgram(len);
		$display("Jumps %0d, branches taken %0d, not taken %0d",
		         jumpCnt, takenCnt, notTakenCnt);
		$display("Commits %0d, errors %0d, timeouts %0d", commitCnt, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verif
hdl/scalarPkg.sv
hdl/instrMem.sv
hdl/fetchUnit.sv
hdl/hazardCheck.sv
hdl/regFile.sv
hdl/sMathUnit.sv
hdl/scalarUnit.sv
verif/tbScalarUnit.sv
